// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --assert --timing -Wno-fatal
TOP       = battleship_tb
FILELIST  = tb.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o sim
	./obj_dir/sim | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== source/battleship_pkg.sv ====
package battleship_pkg;

    // row or column index on the grid
    typedef logic [3:0] coord_t;

    // state of one grid cell
    typedef logic [2:0] cell_t;

    // count of ships placed or still afloat
    typedef logic [3:0] ship_count_t;

    // nothing on this cell
    localparam cell_t CELL_EMPTY = 3'd0;

    // own ship, not hit yet
    localparam cell_t CELL_SHIP = 3'd1;

    // shooter's record of a shot into open water
    localparam cell_t CELL_MISS = 3'd2;

    // own ship that the enemy has hit
    localparam cell_t CELL_HIT = 3'd3;

    // shooter's record of a hit on the enemy
    localparam cell_t CELL_HIT_MARK = 3'd4;

    // referee FSM
    // READY   : accepts a shot
    // SHOWING : result flags are up, shots are dropped
    // OVER    : a fleet is gone, only reset leaves this state
    typedef enum logic [1:0] {
        READY,
        SHOWING,
        OVER
    } referee_state_t;

endpackage

// ==== source/battleship_top.sv ====
`timescale 1ns/1ns

module battleship_top import battleship_pkg::*; #(
    parameter int GRID_SIZE     = 9,
    parameter int MAX_SHIPS     = 5,
    parameter int RESULT_CYCLES = 3_000_000,
    parameter int MOVE_CYCLES   = 2 ** 24
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   view_switch,
    input  logic   confirm_switch,
    input  logic   btnr,
    input  logic   placing_mode,
    input  logic   btn_c,
    input  logic   btn_z,
    input  logic   joy_left,
    input  logic   joy_right,
    input  logic   joy_up,
    input  logic   joy_down,
    input  coord_t view_row,
    input  coord_t view_col,
    output coord_t cursor_row,
    output coord_t cursor_col,
    output cell_t  view_cell,
    output logic   hit,
    output logic   miss,
    output logic   game_over,
    output logic   winner,
    output logic   blackout
);

    logic place_req;
    logic fire_req;
    logic confirm_rise;

    board_if bus_p1 ();
    board_if bus_p2 ();

    player_controls #(
        .GRID_SIZE   (GRID_SIZE),
        .MOVE_CYCLES (MOVE_CYCLES)
    ) controls_i (
        .clk            (clk),
        .reset          (reset),
        .joy_left       (joy_left),
        .joy_right      (joy_right),
        .joy_up         (joy_up),
        .joy_down       (joy_down),
        .btn_c          (btn_c),
        .btn_z          (btn_z),
        .btnr           (btnr),
        .confirm_switch (confirm_switch),
        .cursor_row     (cursor_row),
        .cursor_col     (cursor_col),
        .place_req      (place_req),
        .fire_req       (fire_req),
        .confirm_rise   (confirm_rise)
    );

    referee #(
        .RESULT_CYCLES (RESULT_CYCLES)
    ) referee_i (
        .clk          (clk),
        .reset        (reset),
        .view_switch  (view_switch),
        .placing_mode (placing_mode),
        .place_req    (place_req),
        .fire_req     (fire_req),
        .confirm_rise (confirm_rise),
        .cursor_row   (cursor_row),
        .cursor_col   (cursor_col),
        .view_row     (view_row),
        .view_col     (view_col),
        .p1           (bus_p1.referee),
        .p2           (bus_p2.referee),
        .view_cell    (view_cell),
        .hit          (hit),
        .miss         (miss),
        .game_over    (game_over),
        .winner       (winner),
        .blackout     (blackout)
    );

    fleet_board #(
        .GRID_SIZE (GRID_SIZE),
        .MAX_SHIPS (MAX_SHIPS)
    ) board_p1_i (
        .clk   (clk),
        .reset (reset),
        .bus   (bus_p1.board)
    );

    fleet_board #(
        .GRID_SIZE (GRID_SIZE),
        .MAX_SHIPS (MAX_SHIPS)
    ) board_p2_i (
        .clk   (clk),
        .reset (reset),
        .bus   (bus_p2.board)
    );

endmodule

// ==== source/board_if.sv ====
`timescale 1ns/1ns

// link between one fleet board and the referee
interface board_if import battleship_pkg::*; ();

    // single-cycle strobes from the referee, no acknowledge
    logic place;
    logic sink;
    logic mark_hit;
    logic mark_miss;

    // cursor position, shared by all strobes
    coord_t row;
    coord_t col;

    // board state seen by the referee
    cell_t       target_cell;
    ship_count_t fleet_left;

    // readout port
    coord_t view_row;
    coord_t view_col;
    cell_t  view_cell;

    modport board (
        input  place, sink, mark_hit, mark_miss,
        input  row, col, view_row, view_col,
        output target_cell, fleet_left, view_cell
    );

    modport referee (
        output place, sink, mark_hit, mark_miss,
        output row, col, view_row, view_col,
        input  target_cell, fleet_left, view_cell
    );

endinterface

// ==== source/fleet_board.sv ====
`timescale 1ns/1ns

module fleet_board import battleship_pkg::*; #(
    parameter int GRID_SIZE = 9,
    parameter int MAX_SHIPS = 5
) (
    input logic     clk,
    input logic     reset,
    board_if.board  bus
);

    cell_t       cells [GRID_SIZE][GRID_SIZE];
    ship_count_t placed;
    ship_count_t remaining;
    logic        place_ok;
    logic        view_in_range;

    assign bus.target_cell = cells[bus.row][bus.col];
    assign bus.fleet_left  = remaining;

    // the readout address comes straight from the top level pins
    assign view_in_range = (bus.view_row < coord_t'(GRID_SIZE)) &&
                           (bus.view_col < coord_t'(GRID_SIZE));
    assign bus.view_cell = view_in_range ? cells[bus.view_row][bus.view_col] : CELL_EMPTY;

    // a ship goes only on open water, and only while the fleet is not full
    assign place_ok = bus.place && (bus.target_cell == CELL_EMPTY) &&
                      (placed < ship_count_t'(MAX_SHIPS));

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < GRID_SIZE; r++) begin
                for (int c = 0; c < GRID_SIZE; c++) begin
                    cells[r][c] <= CELL_EMPTY;
                end
            end
        end else if (place_ok) begin
            cells[bus.row][bus.col] <= CELL_SHIP;
        end else if (bus.sink) begin
            cells[bus.row][bus.col] <= CELL_HIT;
        end else if (bus.mark_hit) begin
            cells[bus.row][bus.col] <= CELL_HIT_MARK;
        end else if (bus.mark_miss) begin
            cells[bus.row][bus.col] <= CELL_MISS;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            placed    <= '0;
            remaining <= '0;
        end else if (place_ok) begin
            placed    <= placed + 1'b1;
            remaining <= remaining + 1'b1;
        end else if (bus.sink) begin
            remaining <= remaining - 1'b1;
        end
    end

endmodule

// ==== source/player_controls.sv ====
`timescale 1ns/1ns

module player_controls import battleship_pkg::*; #(
    parameter int GRID_SIZE   = 9,
    parameter int MOVE_CYCLES = 2 ** 24
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   joy_left,
    input  logic   joy_right,
    input  logic   joy_up,
    input  logic   joy_down,
    input  logic   btn_c,
    input  logic   btn_z,
    input  logic   btnr,
    input  logic   confirm_switch,
    output coord_t cursor_row,
    output coord_t cursor_col,
    output logic   place_req,
    output logic   fire_req,
    output logic   confirm_rise
);

    localparam int TICK_W = (MOVE_CYCLES > 1) ? $clog2(MOVE_CYCLES) : 1;
    localparam coord_t LAST_CELL = coord_t'(GRID_SIZE - 1);
    localparam coord_t MID_CELL  = coord_t'(GRID_SIZE / 2);

    logic left_q, right_q, up_q, down_q;
    logic [TICK_W-1:0] move_count;
    logic move_tick;
    logic prev_c, prev_z, prev_btnr, prev_confirm;
    logic btnr_rise;

    // direction levels, one register stage
    always_ff @(posedge clk) begin
        if (reset) begin
            left_q  <= 1'b0;
            right_q <= 1'b0;
            up_q    <= 1'b0;
            down_q  <= 1'b0;
        end else begin
            left_q  <= joy_left;
            right_q <= joy_right;
            up_q    <= joy_up;
            down_q  <= joy_down;
        end
    end

    // slow tick so a held stick steps the cursor at a usable rate
    always_ff @(posedge clk) begin
        if (reset || move_tick) begin
            move_count <= '0;
        end else begin
            move_count <= move_count + 1'b1;
        end
    end

    assign move_tick = (move_count == TICK_W'(MOVE_CYCLES - 1));

    // one step per tick, held at the grid edge
    always_ff @(posedge clk) begin
        if (reset) begin
            cursor_row <= MID_CELL;
            cursor_col <= MID_CELL;
        end else if (move_tick) begin
            if (right_q && cursor_col < LAST_CELL) begin
                cursor_col <= cursor_col + 1'b1;
            end else if (left_q && cursor_col > '0) begin
                cursor_col <= cursor_col - 1'b1;
            end
            if (down_q && cursor_row < LAST_CELL) begin
                cursor_row <= cursor_row + 1'b1;
            end else if (up_q && cursor_row > '0) begin
                cursor_row <= cursor_row - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_c       <= 1'b0;
            prev_z       <= 1'b0;
            prev_btnr    <= 1'b0;
            prev_confirm <= 1'b0;
        end else begin
            prev_c       <= btn_c;
            prev_z       <= btn_z;
            prev_btnr    <= btnr;
            prev_confirm <= confirm_switch;
        end
    end

    // btnr serves both placing and firing, the referee picks by mode
    assign btnr_rise    = btnr & ~prev_btnr;
    assign place_req    = (btn_c & ~prev_c) | btnr_rise;
    assign fire_req     = (btn_z & ~prev_z) | btnr_rise;
    assign confirm_rise = confirm_switch & ~prev_confirm;

endmodule

// ==== source/referee.sv ====
`timescale 1ns/1ns

module referee import battleship_pkg::*; #(
    parameter int RESULT_CYCLES = 3_000_000
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      view_switch,
    input  logic      placing_mode,
    input  logic      place_req,
    input  logic      fire_req,
    input  logic      confirm_rise,
    input  coord_t    cursor_row,
    input  coord_t    cursor_col,
    input  coord_t    view_row,
    input  coord_t    view_col,
    board_if.referee  p1,
    board_if.referee  p2,
    output cell_t     view_cell,
    output logic      hit,
    output logic      miss,
    output logic      game_over,
    output logic      winner,
    output logic      blackout
);

    localparam int TIMER_W = $clog2(RESULT_CYCLES + 1);

    referee_state_t     state;
    logic [TIMER_W-1:0] result_timer;
    logic               timer_last;
    cell_t              target_cell;
    ship_count_t        target_left;
    logic               own_place;
    logic               shot;
    logic               shot_hit;
    logic               shot_miss;
    logic               last_ship;
    logic               stored_view;

    // both boards see the same cursor and readout address
    assign p1.row      = cursor_row;
    assign p1.col      = cursor_col;
    assign p2.row      = cursor_row;
    assign p2.col      = cursor_col;
    assign p1.view_row = view_row;
    assign p1.view_col = view_col;
    assign p2.view_row = view_row;
    assign p2.view_col = view_col;

    // view_switch low: own board is p1 and the target is p2
    assign view_cell   = view_switch ? p2.view_cell : p1.view_cell;
    assign target_cell = view_switch ? p1.target_cell : p2.target_cell;
    assign target_left = view_switch ? p1.fleet_left : p2.fleet_left;

    assign own_place = !placing_mode && place_req && (state != OVER);
    assign shot      = placing_mode && fire_req && (state == READY);
    assign shot_hit  = shot && (target_cell == CELL_SHIP);
    assign shot_miss = shot && (target_cell == CELL_EMPTY);
    assign last_ship = shot_hit && (target_left == ship_count_t'(1));

    assign p1.place     = own_place && !view_switch;
    assign p2.place     = own_place && view_switch;
    assign p1.sink      = shot_hit && view_switch;
    assign p2.sink      = shot_hit && !view_switch;
    assign p1.mark_hit  = shot_hit && !view_switch;
    assign p2.mark_hit  = shot_hit && view_switch;
    assign p1.mark_miss = shot_miss && !view_switch;
    assign p2.mark_miss = shot_miss && view_switch;

    assign timer_last = (result_timer == TIMER_W'(1));
    assign game_over  = (state == OVER);

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= READY;
            result_timer <= '0;
            hit          <= 1'b0;
            miss         <= 1'b0;
            winner       <= 1'b0;
        end else begin
            // result timer keeps running in OVER so the last flag still drops
            if (result_timer != '0) begin
                result_timer <= result_timer - 1'b1;
                if (timer_last) begin
                    hit  <= 1'b0;
                    miss <= 1'b0;
                end
            end
            case (state)
                READY: begin
                    if (shot_hit || shot_miss) begin
                        result_timer <= TIMER_W'(RESULT_CYCLES);
                        hit          <= shot_hit;
                        miss         <= shot_miss;
                        if (last_ship) begin
                            state  <= OVER;
                            // high when player 1 sank the p2 fleet
                            winner <= !view_switch;
                        end else begin
                            state <= SHOWING;
                        end
                    end
                end
                SHOWING: begin
                    if (timer_last) begin
                        state <= READY;
                    end
                end
                default: begin
                    state <= OVER;
                end
            endcase
        end
    end

    // hide both boards between confirm and the next player's switch flip
    always_ff @(posedge clk) begin
        if (reset) begin
            blackout <= 1'b0;
        end else if (confirm_rise) begin
            blackout <= 1'b1;
        end else if (blackout && view_switch != stored_view) begin
            blackout <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (confirm_rise) begin
            stored_view <= view_switch;
        end
    end

endmodule

// ==== tb.f ====
source/battleship_pkg.sv
source/board_if.sv
source/player_controls.sv
source/fleet_board.sv
source/referee.sv
source/battleship_top.sv
testbench/battleship_properties.sv
testbench/battleship_tb.sv

// ==== testbench/battleship_properties.sv ====
`timescale 1ns/1ns

module battleship_properties import battleship_pkg::*; #(
    parameter int GRID_SIZE     = 9,
    parameter int MAX_SHIPS     = 5,
    parameter int RESULT_CYCLES = 20
) (
    input logic   clk,
    input logic   reset,
    input logic   view_switch,
    input logic   confirm_switch,
    input logic   btnr,
    input logic   placing_mode,
    input logic   btn_c,
    input logic   btn_z,
    input logic   joy_left,
    input coord_t view_row,
    input coord_t view_col,
    input coord_t cursor_row,
    input coord_t cursor_col,
    input cell_t  view_cell,
    input logic   hit,
    input logic   miss,
    input logic   game_over,
    input logic   winner,
    input logic   blackout
);

    localparam coord_t MID_CELL = coord_t'(GRID_SIZE / 2);

    logic        prev_c;
    logic        prev_z;
    logic        prev_btnr;
    logic        prev_confirm;
    logic        stored_view;
    logic        place_press;
    logic        fire_press;
    logic        confirm_press;
    logic        at_cursor;
    logic        tgt;
    logic        tgt_ship;
    logic        tgt_used;
    logic        view_sunk;
    logic        room_left;
    // shadow of both grids where index 0 is player 1
    logic        ships [2][GRID_SIZE][GRID_SIZE];
    logic        used  [2][GRID_SIZE][GRID_SIZE];
    logic        sunk  [2][GRID_SIZE][GRID_SIZE];
    ship_count_t placed [2];
    ship_count_t afloat [2];
    int          result_len;
    int          fail_count = 0;

    assign place_press   = !placing_mode && !game_over &&
                           ((btn_c && !prev_c) || (btnr && !prev_btnr));
    assign fire_press    = placing_mode && !hit && !miss && !game_over &&
                           ((btn_z && !prev_z) || (btnr && !prev_btnr));
    assign confirm_press = confirm_switch && !prev_confirm;
    assign at_cursor     = (view_row == cursor_row) && (view_col == cursor_col);
    assign tgt           = !view_switch;
    assign tgt_ship      = ships[tgt][cursor_row][cursor_col];
    assign tgt_used      = used[tgt][cursor_row][cursor_col];
    assign view_sunk     = sunk[view_switch][view_row][view_col];
    assign room_left     = placed[view_switch] < ship_count_t'(MAX_SHIPS);

    always_ff @(posedge clk) begin
        prev_c       <= btn_c;
        prev_z       <= btn_z;
        prev_btnr    <= btnr;
        prev_confirm <= confirm_switch;
        if (confirm_press) begin
            stored_view <= view_switch;
        end
        if (reset) begin
            ships      <= '{default: '0};
            used       <= '{default: '0};
            sunk       <= '{default: '0};
            placed     <= '{default: '0};
            afloat     <= '{default: '0};
            result_len <= 0;
        end else begin
            if (place_press && at_cursor && view_cell == CELL_EMPTY && room_left) begin
                ships[view_switch][cursor_row][cursor_col] <= 1'b1;
                used[view_switch][cursor_row][cursor_col]  <= 1'b1;
                placed[view_switch] <= placed[view_switch] + 1'b1;
                afloat[view_switch] <= afloat[view_switch] + 1'b1;
            end
            if (fire_press && tgt_ship) begin
                ships[tgt][cursor_row][cursor_col]        <= 1'b0;
                sunk[tgt][cursor_row][cursor_col]         <= 1'b1;
                afloat[tgt]                               <= afloat[tgt] - 1'b1;
                used[view_switch][cursor_row][cursor_col] <= 1'b1;
            end else if (fire_press && !tgt_used) begin
                used[view_switch][cursor_row][cursor_col] <= 1'b1;
            end
            result_len <= (hit || miss) ? result_len + 1 : 0;
        end
    end

    reset_state: assert property (@(posedge clk) $past(reset) |->
        !hit && !miss && !game_over && !winner && !blackout &&
        (reset || (cursor_row == MID_CELL && cursor_col == MID_CELL)))
    else begin
        fail_count++;
        $error("CHECK FAILED reset state cursor=%h,%h hit=%h", cursor_row, cursor_col, hit);
    end

    cursor_range: assert property (@(posedge clk) disable iff (reset)
        cursor_row < coord_t'(GRID_SIZE) && cursor_col < coord_t'(GRID_SIZE))
    else begin
        fail_count++;
        $error("CHECK FAILED cursor_row=%h cursor_col=%h", cursor_row, cursor_col);
    end

    // without left held the column can only grow
    cursor_right: assert property (@(posedge clk) disable iff (reset)
        !$past(joy_left) && !$past(joy_left, 2) |-> cursor_col >= $past(cursor_col))
    else begin
        fail_count++;
        $error("CHECK FAILED cursor_col=%h previous %h", cursor_col, $past(cursor_col));
    end

    place_check: assert property (@(posedge clk) disable iff (reset)
        place_press && at_cursor && view_cell == CELL_EMPTY |=>
        view_cell == ($past(room_left) ? CELL_SHIP : CELL_EMPTY))
    else begin
        fail_count++;
        $error("CHECK FAILED view_cell=%h after placement", view_cell);
    end

    shot_hit: assert property (@(posedge clk) disable iff (reset)
        fire_press && at_cursor && tgt_ship |=> hit && view_cell == CELL_HIT_MARK)
    else begin
        fail_count++;
        $error("CHECK FAILED hit=%h view_cell=%h expected 1 and %h", hit, view_cell,
               CELL_HIT_MARK);
    end

    shot_miss: assert property (@(posedge clk) disable iff (reset)
        fire_press && at_cursor && !tgt_used |=> miss && view_cell == CELL_MISS)
    else begin
        fail_count++;
        $error("CHECK FAILED miss=%h view_cell=%h expected 1 and %h", miss, view_cell,
               CELL_MISS);
    end

    sunk_view: assert property (@(posedge clk) disable iff (reset)
        view_sunk |-> view_cell == CELL_HIT)
    else begin
        fail_count++;
        $error("CHECK FAILED view_cell=%h expected %h", view_cell, CELL_HIT);
    end

    flags_exclusive: assert property (@(posedge clk) disable iff (reset) !(hit && miss))
    else begin
        fail_count++;
        $error("CHECK FAILED hit=%h miss=%h", hit, miss);
    end

    result_bound: assert property (@(posedge clk) disable iff (reset)
        (hit || miss) |-> result_len < RESULT_CYCLES)
    else begin
        fail_count++;
        $error("CHECK FAILED result length %h over %h", result_len, RESULT_CYCLES);
    end

    result_length: assert property (@(posedge clk) disable iff (reset)
        $past(hit || miss) && !(hit || miss) |-> $past(result_len) == RESULT_CYCLES - 1)
    else begin
        fail_count++;
        $error("CHECK FAILED result length %h expected %h", $past(result_len) + 1,
               RESULT_CYCLES);
    end

    showing_ignore: assert property (@(posedge clk) disable iff (reset)
        placing_mode && btn_z && !prev_z && (hit || miss) && at_cursor |=>
        !$rose(hit) && !$rose(miss) && $stable(view_cell))
    else begin
        fail_count++;
        $error("CHECK FAILED hit=%h miss=%h view_cell=%h during result", hit, miss, view_cell);
    end

    // index 1 of the shadow is player 2 whose loss makes winner high
    last_ship: assert property (@(posedge clk) disable iff (reset)
        fire_press && tgt_ship && afloat[tgt] == ship_count_t'(1) |=>
        game_over && hit && winner == $past(tgt))
    else begin
        fail_count++;
        $error("CHECK FAILED game_over=%h hit=%h winner=%h", game_over, hit, winner);
    end

    over_sticky: assert property (@(posedge clk) disable iff (reset)
        $past(game_over) |-> game_over && !$rose(hit) && !$rose(miss))
    else begin
        fail_count++;
        $error("CHECK FAILED game_over=%h hit=%h miss=%h after end", game_over, hit, miss);
    end

    blackout_set: assert property (@(posedge clk) disable iff (reset)
        confirm_press |=> blackout)
    else begin
        fail_count++;
        $error("CHECK FAILED blackout=%h after confirm", blackout);
    end

    blackout_follow: assert property (@(posedge clk) disable iff (reset)
        blackout && !confirm_press |=> blackout == $past(view_switch == stored_view))
    else begin
        fail_count++;
        $error("CHECK FAILED blackout=%h view_switch=%h", blackout, view_switch);
    end

endmodule

bind battleship_top battleship_properties #(
    .GRID_SIZE     (GRID_SIZE),
    .MAX_SHIPS     (MAX_SHIPS),
    .RESULT_CYCLES (RESULT_CYCLES)
) props_i (.*);

// ==== testbench/battleship_tb.sv ====
`timescale 1ns/1ns

module battleship_tb import battleship_pkg::*; ();

    localparam int GRID_SIZE = 9;
    localparam int SHOTS     = 7;

    logic   clk;
    logic   reset;
    logic   view_switch;
    logic   confirm_switch;
    logic   btnr;
    logic   placing_mode;
    logic   btn_c;
    logic   btn_z;
    logic   joy_left;
    logic   joy_right;
    logic   joy_up;
    logic   joy_down;
    coord_t view_row;
    coord_t view_col;
    coord_t cursor_row;
    coord_t cursor_col;
    cell_t  view_cell;
    logic   hit;
    logic   miss;
    logic   game_over;
    logic   winner;
    logic   blackout;
    integer seed;
    coord_t cell_r [SHOTS];
    coord_t cell_c [SHOTS];

    battleship_top #(
        .GRID_SIZE     (GRID_SIZE),
        .MAX_SHIPS     (5),
        .RESULT_CYCLES (20),
        .MOVE_CYCLES   (8)
    ) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_with_failure(input string reason);
        $display("TESTS FAILED");
        $fatal(1, "%s", reason);
    endtask

    always @(posedge clk) begin
        if (dut_i.props_i.fail_count != 0) begin
            stop_with_failure("a bound assertion failed");
        end
    end

    task automatic step(input int n);
        repeat (n) @(negedge clk);
    endtask

    // distinct random cells with the last one kept free of ships
    task automatic pick_cells();
        logic [31:0] rv;
        logic        clash;
        for (int i = 0; i < SHOTS; i++) begin
            do begin
                rv = $random(seed);
                cell_r[i] = coord_t'(rv[15:0] % GRID_SIZE);
                cell_c[i] = coord_t'(rv[31:16] % GRID_SIZE);
                clash = 1'b0;
                for (int j = 0; j < i; j++) begin
                    if (cell_r[j] == cell_r[i] && cell_c[j] == cell_c[i]) begin
                        clash = 1'b1;
                    end
                end
            end while (clash);
        end
    endtask

    task automatic move_to(input coord_t r, input coord_t c);
        int cycles;
        cycles = 0;
        while (cursor_row != r || cursor_col != c) begin
            @(negedge clk);
            joy_right = cursor_col < c;
            joy_left  = cursor_col > c;
            joy_down  = cursor_row < r;
            joy_up    = cursor_row > r;
            cycles++;
            if (cycles > 500) begin
                stop_with_failure("cursor did not reach the requested cell");
            end
        end
        @(negedge clk);
        {joy_left, joy_right, joy_up, joy_down} = 4'b0;
        step(2);
        view_row = cursor_row;
        view_col = cursor_col;
        step(1);
    endtask

    // kind selects btn_c (0), btnr (1) or btn_z (2)
    task automatic press_button(input int kind);
        @(negedge clk);
        btn_c = (kind == 0);
        btnr  = (kind == 1);
        btn_z = (kind == 2);
        @(negedge clk);
        {btn_c, btnr, btn_z} = 3'b0;
        step(2);
    endtask

    // step one column toward the middle and fire while the result still shows
    task automatic fire_while_showing();
        int     cycles;
        coord_t start_col;
        start_col = cursor_col;
        cycles = 0;
        @(negedge clk);
        joy_left  = cursor_col > coord_t'(GRID_SIZE / 2);
        joy_right = !joy_left;
        while (cursor_col == start_col) begin
            @(negedge clk);
            cycles++;
            if (cycles > 16) begin
                stop_with_failure("cursor did not step while the result showed");
            end
        end
        {joy_left, joy_right} = 2'b0;
        view_row = cursor_row;
        view_col = cursor_col;
        btn_z    = 1'b1;
        @(negedge clk);
        btn_z = 1'b0;
        step(2);
    endtask

    task automatic wait_result_clear();
        int cycles;
        cycles = 0;
        while (hit || miss) begin
            step(1);
            cycles++;
            if (cycles > 100) begin
                stop_with_failure("result flags never dropped");
            end
        end
    endtask

    initial begin
        int cycles;
        seed = 32'h2897_69bb;
        reset = 1'b1;
        {view_switch, confirm_switch, btnr, placing_mode, btn_c, btn_z} = 6'b0;
        {joy_left, joy_right, joy_up, joy_down} = 4'b0;
        view_row = '0;
        view_col = '0;
        pick_cells();
        step(16);
        reset = 1'b0;
        step(2);

        // hold right until the edge and keep holding
        joy_right = 1'b1;
        cycles = 0;
        while (cursor_col != coord_t'(GRID_SIZE - 1)) begin
            step(1);
            cycles++;
            if (cycles > 200) begin
                stop_with_failure("cursor never reached the right edge");
            end
        end
        step(24);
        joy_right = 1'b0;
        step(2);

        // player 2 places five ships and the sixth is refused
        view_switch = 1'b1;
        for (int i = 0; i < 6; i++) begin
            move_to(cell_r[i], cell_c[i]);
            press_button((i == 2) ? 1 : 0);
        end

        confirm_switch = 1'b1;
        step(3);
        view_switch = 1'b0;
        step(3);
        confirm_switch = 1'b0;
        step(1);

        // player 1 fires a miss first with a second shot while it shows
        placing_mode = 1'b1;
        move_to(cell_r[6], cell_c[6]);
        press_button(2);
        fire_while_showing();
        wait_result_clear();
        for (int i = 0; i < 5; i++) begin
            move_to(cell_r[i], cell_c[i]);
            press_button(2);
            if (i == 0) begin
                view_switch = 1'b1;
                step(2);
                view_switch = 1'b0;
                step(2);
            end
            wait_result_clear();
        end

        // one more shot after the end of the game
        move_to(cell_r[5], cell_c[5]);
        press_button(2);
        step(5);

        if (dut_i.props_i.fail_count == 0 && game_over) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            stop_with_failure("game did not end as expected");
        end
    end

endmodule
